//--- rtl/trace_settings.svh
// trace unit settings, widths of tags, stamps, words and totals, plus table depth
`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

// tag width, enough to index every table entry
`define TRACE_TAG_W 3

// table entries, at least five in flight
`define TRACE_DEPTH 8

// free-running cycle counter and every stage stamp
`define TRACE_CYCLE_W 16

// host instruction word
`define TRACE_INSTR_W 32

// per-instruction stall counter
`define TRACE_STALL_W 8

// retired and killed running totals
`define TRACE_TOTAL_W 16

`endif

//--- rtl/trace_pkg.sv
// trace unit types, shared by the tracker, the record table and the reporter
`include "trace_settings.svh"

package trace_pkg;

    //////////////////////////////////////////////////////////////////////
    // tags and words
    //////////////////////////////////////////////////////////////////////

    // instruction tag, given in fetch order
    // wraps modulo the table depth
    typedef logic [`TRACE_TAG_W-1:0] tag_t;

    // host instruction word, stored as sampled at fetch
    typedef logic [`TRACE_INSTR_W-1:0] instr_t;

    //////////////////////////////////////////////////////////////////////
    // counts and stamps
    //////////////////////////////////////////////////////////////////////

    // cycle counter value
    // also the stamp of a stage entry
    // also the retire latency
    typedef logic [`TRACE_CYCLE_W-1:0] cycle_t;

    // cycles an instruction is held in fetch or decode
    typedef logic [`TRACE_STALL_W-1:0] stall_cnt_t;

    // running totals of retired and killed instructions
    typedef logic [`TRACE_TOTAL_W-1:0] total_t;

endpackage

//--- rtl/stage_tracker.sv
// stage tracker, follows tags through fetch to write-back and raises the table strobes
`timescale 1ns/1ns
`include "trace_settings.svh"

module stage_tracker (
    input  logic                clk,
    input  logic                rst,
    input  logic                fetch_valid,
    input  trace_pkg::instr_t   instr,
    input  logic                stall,
    input  logic                flush,
    output trace_pkg::cycle_t   cycle,
    output logic                alloc,
    output trace_pkg::tag_t     alloc_tag,
    output trace_pkg::instr_t   alloc_instr,
    output logic                d_enter,
    output trace_pkg::tag_t     d_tag,
    output logic                e_enter,
    output trace_pkg::tag_t     e_tag,
    output logic                m_enter,
    output trace_pkg::tag_t     m_tag,
    output logic                w_enter,
    output trace_pkg::tag_t     w_tag,
    output logic                f_hold,
    output trace_pkg::tag_t     f_tag,
    output logic                d_hold,
    output trace_pkg::tag_t     d_hold_tag,
    output logic [1:0]          kill_count
);

    // occupancy of fetch, decode, execute and memory
    // write-back occupancy is the reporter's registered record
    logic f_valid;
    logic d_valid;
    logic e_valid;
    logic m_valid;
    trace_pkg::tag_t f_tag_r;
    trace_pkg::tag_t d_tag_r;
    trace_pkg::tag_t e_tag_r;
    trace_pkg::tag_t m_tag_r;
    trace_pkg::tag_t next_tag;

    // front stages move only without stall, or on flush
    logic front_move;
    logic held;

    assign front_move = flush | ~stall;
    assign held = stall & ~flush;

    //////////////////////////////////////////////////////////////////////
    // strobes for the coming edge
    //////////////////////////////////////////////////////////////////////

    assign alloc = fetch_valid & front_move;
    assign alloc_tag = next_tag;
    assign alloc_instr = instr;

    // decode and execute are refilled only on a plain advance
    assign d_enter = f_valid & ~stall & ~flush;
    assign d_tag = f_tag_r;
    assign e_enter = d_valid & ~stall & ~flush;
    assign e_tag = d_tag_r;

    // back end never stops
    assign m_enter = e_valid;
    assign m_tag = e_tag_r;
    assign w_enter = m_valid;
    assign w_tag = m_tag_r;

    assign f_hold = f_valid & held;
    assign f_tag = f_tag_r;
    assign d_hold = d_valid & held;
    assign d_hold_tag = d_tag_r;

    // fetch and decode occupants lost on flush
    assign kill_count = flush ? ({1'b0, f_valid} + {1'b0, d_valid}) : 2'd0;

    //////////////////////////////////////////////////////////////////////
    // control state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
            next_tag <= '0;
            f_valid <= 1'b0;
            d_valid <= 1'b0;
            e_valid <= 1'b0;
            m_valid <= 1'b0;
        end else begin
            cycle <= cycle + 1'b1;
            m_valid <= e_valid;
            if (alloc) begin
                // wrap at table depth
                if (next_tag == trace_pkg::tag_t'(`TRACE_DEPTH - 1)) begin
                    next_tag <= '0;
                end else begin
                    next_tag <= next_tag + 1'b1;
                end
            end
            if (flush) begin
                f_valid <= fetch_valid;
                d_valid <= 1'b0;
                e_valid <= 1'b0;
            end else if (stall) begin
                // bubble into execute
                e_valid <= 1'b0;
            end else begin
                f_valid <= fetch_valid;
                d_valid <= f_valid;
                e_valid <= d_valid;
            end
        end
    end

    // stage tags follow the valid bits
    always_ff @(posedge clk) begin
        m_tag_r <= e_tag_r;
        if (front_move) begin
            f_tag_r <= next_tag;
        end
        if (~stall & ~flush) begin
            d_tag_r <= f_tag_r;
            e_tag_r <= d_tag_r;
        end
    end

endmodule

//--- rtl/trace_table.sv
// trace record table, per-tag stamps and stall counts written at stage entry
`timescale 1ns/1ns
`include "trace_settings.svh"

module trace_table (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   alloc,
    input  trace_pkg::tag_t        alloc_tag,
    input  trace_pkg::instr_t      instr,
    input  logic                   d_enter,
    input  trace_pkg::tag_t        d_tag,
    input  logic                   e_enter,
    input  trace_pkg::tag_t        e_tag,
    input  logic                   m_enter,
    input  trace_pkg::tag_t        m_tag,
    input  logic                   w_enter,
    input  trace_pkg::tag_t        w_tag,
    input  logic                   f_hold,
    input  trace_pkg::tag_t        f_tag,
    input  logic                   d_hold,
    input  trace_pkg::tag_t        d_hold_tag,
    input  trace_pkg::cycle_t      cycle,
    output trace_pkg::tag_t        rec_tag,
    output trace_pkg::instr_t      rec_instr,
    output trace_pkg::cycle_t      rec_fetch_cycle,
    output trace_pkg::cycle_t      rec_exec_cycle,
    output trace_pkg::stall_cnt_t  rec_stall
);

    //////////////////////////////////////////////////////////////////////
    // record storage, one slot per tag
    //////////////////////////////////////////////////////////////////////

    trace_pkg::instr_t     instr_mem  [`TRACE_DEPTH];
    trace_pkg::cycle_t     fetch_mem  [`TRACE_DEPTH];
    trace_pkg::cycle_t     decode_mem [`TRACE_DEPTH];
    trace_pkg::cycle_t     exec_mem   [`TRACE_DEPTH];
    trace_pkg::cycle_t     memory_mem [`TRACE_DEPTH];
    trace_pkg::stall_cnt_t stall_mem  [`TRACE_DEPTH];

    // alloc and hold never share an edge
    // so one slot sees one of the two at most
    always_ff @(posedge clk) begin
        if (!rst) begin
            if (alloc) begin
                // fresh record for a new fetch
                instr_mem[alloc_tag] <= instr;
                fetch_mem[alloc_tag] <= cycle;
                decode_mem[alloc_tag] <= '0;
                exec_mem[alloc_tag] <= '0;
                memory_mem[alloc_tag] <= '0;
                stall_mem[alloc_tag] <= '0;
            end

            // stage entry stamps
            if (d_enter) begin
                decode_mem[d_tag] <= cycle;
            end
            if (e_enter) begin
                exec_mem[e_tag] <= cycle;
            end
            if (m_enter) begin
                memory_mem[m_tag] <= cycle;
            end

            // one count per held edge
            // fetch and decode occupants always carry different tags
            if (f_hold) begin
                stall_mem[f_tag] <= stall_mem[f_tag] + 1'b1;
            end
            if (d_hold) begin
                stall_mem[d_hold_tag] <= stall_mem[d_hold_tag] + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // retiring record
    //////////////////////////////////////////////////////////////////////

    // zero outside write-back entry
    always_comb begin
        if (w_enter) begin
            rec_tag = w_tag;
            rec_instr = instr_mem[w_tag];
            rec_fetch_cycle = fetch_mem[w_tag];
            rec_exec_cycle = exec_mem[w_tag];
            rec_stall = stall_mem[w_tag];
        end else begin
            rec_tag = '0;
            rec_instr = '0;
            rec_fetch_cycle = '0;
            rec_exec_cycle = '0;
            rec_stall = '0;
        end
    end

endmodule

//--- rtl/retire_reporter.sv
// retire reporter, registers the retiring record with its latency and keeps totals
`timescale 1ns/1ns
`include "trace_settings.svh"

module retire_reporter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   w_enter,
    input  trace_pkg::cycle_t      cycle,
    input  trace_pkg::tag_t        rec_tag,
    input  trace_pkg::instr_t      rec_instr,
    input  trace_pkg::cycle_t      rec_fetch_cycle,
    input  trace_pkg::cycle_t      rec_exec_cycle,
    input  trace_pkg::stall_cnt_t  rec_stall,
    input  logic [1:0]             kill_count,
    output logic                   retire,
    output trace_pkg::tag_t        retire_tag,
    output trace_pkg::instr_t      retire_instr,
    output trace_pkg::cycle_t      retire_fetch_cycle,
    output trace_pkg::cycle_t      retire_exec_cycle,
    output trace_pkg::cycle_t      retire_latency,
    output trace_pkg::stall_cnt_t  retire_stall_cycles,
    output trace_pkg::total_t      retired_count,
    output trace_pkg::total_t      killed_count
);

    //////////////////////////////////////////////////////////////////////
    // retire record
    //////////////////////////////////////////////////////////////////////

    // one-cycle pulse, record held until the next retire
    always_ff @(posedge clk) begin
        if (rst) begin
            retire <= 1'b0;
            retire_tag <= '0;
            retire_instr <= '0;
            retire_fetch_cycle <= '0;
            retire_exec_cycle <= '0;
            retire_latency <= '0;
            retire_stall_cycles <= '0;
        end else begin
            retire <= w_enter;
            if (w_enter) begin
                retire_tag <= rec_tag;
                retire_instr <= rec_instr;
                retire_fetch_cycle <= rec_fetch_cycle;
                retire_exec_cycle <= rec_exec_cycle;
                // write-back stamp minus fetch stamp
                retire_latency <= cycle - rec_fetch_cycle;
                retire_stall_cycles <= rec_stall;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // running totals
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            retired_count <= '0;
            killed_count <= '0;
        end else begin
            if (w_enter) begin
                retired_count <= retired_count + 1'b1;
            end
            // zero except on a flush edge
            killed_count <= killed_count + trace_pkg::total_t'(kill_count);
        end
    end

endmodule

//--- rtl/pipe_trace_top.sv
// pipeline trace unit top, stage tracking into the record table into retire reporting
`timescale 1ns/1ns
`include "trace_settings.svh"

module pipe_trace_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_valid,
    input  trace_pkg::instr_t      instr,
    input  logic                   stall,
    input  logic                   flush,
    output logic                   retire,
    output trace_pkg::tag_t        retire_tag,
    output trace_pkg::instr_t      retire_instr,
    output trace_pkg::cycle_t      retire_fetch_cycle,
    output trace_pkg::cycle_t      retire_exec_cycle,
    output trace_pkg::cycle_t      retire_latency,
    output trace_pkg::stall_cnt_t  retire_stall_cycles,
    output trace_pkg::total_t      retired_count,
    output trace_pkg::total_t      killed_count
);

    //////////////////////////////////////////////////////////////////////
    // tracker to table strobes
    //////////////////////////////////////////////////////////////////////

    trace_pkg::cycle_t     cycle;
    logic                  alloc;
    trace_pkg::tag_t       alloc_tag;
    trace_pkg::instr_t     alloc_instr;
    logic                  d_enter;
    trace_pkg::tag_t       d_tag;
    logic                  e_enter;
    trace_pkg::tag_t       e_tag;
    logic                  m_enter;
    trace_pkg::tag_t       m_tag;
    logic                  w_enter;
    trace_pkg::tag_t       w_tag;
    logic                  f_hold;
    trace_pkg::tag_t       f_tag;
    logic                  d_hold;
    trace_pkg::tag_t       d_hold_tag;
    logic [1:0]            kill_count;

    // retiring record, table to reporter
    trace_pkg::tag_t       rec_tag;
    trace_pkg::instr_t     rec_instr;
    trace_pkg::cycle_t     rec_fetch_cycle;
    trace_pkg::cycle_t     rec_exec_cycle;
    trace_pkg::stall_cnt_t rec_stall;

    stage_tracker i_stage_tracker (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .instr       (instr),
        .stall       (stall),
        .flush       (flush),
        .cycle       (cycle),
        .alloc       (alloc),
        .alloc_tag   (alloc_tag),
        .alloc_instr (alloc_instr),
        .d_enter     (d_enter),
        .d_tag       (d_tag),
        .e_enter     (e_enter),
        .e_tag       (e_tag),
        .m_enter     (m_enter),
        .m_tag       (m_tag),
        .w_enter     (w_enter),
        .w_tag       (w_tag),
        .f_hold      (f_hold),
        .f_tag       (f_tag),
        .d_hold      (d_hold),
        .d_hold_tag  (d_hold_tag),
        .kill_count  (kill_count)
    );

    trace_table i_trace_table (
        .clk             (clk),
        .rst             (rst),
        .alloc           (alloc),
        .alloc_tag       (alloc_tag),
        .instr           (alloc_instr),
        .d_enter         (d_enter),
        .d_tag           (d_tag),
        .e_enter         (e_enter),
        .e_tag           (e_tag),
        .m_enter         (m_enter),
        .m_tag           (m_tag),
        .w_enter         (w_enter),
        .w_tag           (w_tag),
        .f_hold          (f_hold),
        .f_tag           (f_tag),
        .d_hold          (d_hold),
        .d_hold_tag      (d_hold_tag),
        .cycle           (cycle),
        .rec_tag         (rec_tag),
        .rec_instr       (rec_instr),
        .rec_fetch_cycle (rec_fetch_cycle),
        .rec_exec_cycle  (rec_exec_cycle),
        .rec_stall       (rec_stall)
    );

    // w_enter and cycle go straight from the tracker
    retire_reporter i_retire_reporter (
        .clk                 (clk),
        .rst                 (rst),
        .w_enter             (w_enter),
        .cycle               (cycle),
        .rec_tag             (rec_tag),
        .rec_instr           (rec_instr),
        .rec_fetch_cycle     (rec_fetch_cycle),
        .rec_exec_cycle      (rec_exec_cycle),
        .rec_stall           (rec_stall),
        .kill_count          (kill_count),
        .retire              (retire),
        .retire_tag          (retire_tag),
        .retire_instr        (retire_instr),
        .retire_fetch_cycle  (retire_fetch_cycle),
        .retire_exec_cycle   (retire_exec_cycle),
        .retire_latency      (retire_latency),
        .retire_stall_cycles (retire_stall_cycles),
        .retired_count       (retired_count),
        .killed_count        (killed_count)
    );

endmodule

//--- sim/tb_pipe_trace.sv
// pipeline trace testbench running directed tests against a reference stage model
`timescale 1ns/1ns
`include "trace_settings.svh"

module tb_pipe_trace;

    logic                  clk;
    logic                  rst;
    logic                  fetch_valid;
    trace_pkg::instr_t     instr;
    logic                  stall;
    logic                  flush;
    logic                  retire;
    trace_pkg::tag_t       retire_tag;
    trace_pkg::instr_t     retire_instr;
    trace_pkg::cycle_t     retire_fetch_cycle;
    trace_pkg::cycle_t     retire_exec_cycle;
    trace_pkg::cycle_t     retire_latency;
    trace_pkg::stall_cnt_t retire_stall_cycles;
    trace_pkg::total_t     retired_count;
    trace_pkg::total_t     killed_count;

    // one observed retire with the negedge index it was seen at
    typedef struct packed {
        trace_pkg::tag_t       tag;
        trace_pkg::instr_t     instr;
        trace_pkg::cycle_t     fetch;
        trace_pkg::cycle_t     exec;
        trace_pkg::cycle_t     latency;
        trace_pkg::stall_cnt_t stall;
        logic [31:0]           at;
    } retire_rec_t;

    retire_rec_t ret_q [$];
    int mismatch_errors = 0;
    int other_errors = 0;
    int neg_count = 0;

    // counter value at the first fetch edge after reset
    localparam int first_fetch = 1;

    pipe_trace_top i_dut (
        .clk                 (clk),
        .rst                 (rst),
        .fetch_valid         (fetch_valid),
        .instr               (instr),
        .stall               (stall),
        .flush               (flush),
        .retire              (retire),
        .retire_tag          (retire_tag),
        .retire_instr        (retire_instr),
        .retire_fetch_cycle  (retire_fetch_cycle),
        .retire_exec_cycle   (retire_exec_cycle),
        .retire_latency      (retire_latency),
        .retire_stall_cycles (retire_stall_cycles),
        .retired_count       (retired_count),
        .killed_count        (killed_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // reference stage model
    //////////////////////////////////////////////////////////////////////

    localparam int s_fetch = 0;
    localparam int s_decode = 1;
    localparam int s_exec = 2;
    localparam int s_mem = 3;

    // fetch to memory stages
    // write-back shows up as the expected record
    logic                  p_valid [4];
    trace_pkg::tag_t       p_tag   [4];
    trace_pkg::instr_t     p_instr [4];
    trace_pkg::cycle_t     p_fetch [4];
    trace_pkg::cycle_t     p_exec  [4];
    trace_pkg::stall_cnt_t p_stall [4];
    trace_pkg::cycle_t     model_cycle;
    trace_pkg::tag_t       model_next_tag;
    logic                  model_ready = 1'b0;

    // expected retire for the cycle after the edge
    logic                  exp_retire;
    trace_pkg::tag_t       exp_tag;
    trace_pkg::instr_t     exp_instr;
    trace_pkg::cycle_t     exp_fetch;
    trace_pkg::cycle_t     exp_exec;
    trace_pkg::cycle_t     exp_latency;
    trace_pkg::stall_cnt_t exp_stall;
    trace_pkg::total_t     exp_retired;
    trace_pkg::total_t     exp_killed;

    task automatic copy_stage(input int src, input int dst);
        p_valid[dst] = p_valid[src];
        p_tag[dst] = p_tag[src];
        p_instr[dst] = p_instr[src];
        p_fetch[dst] = p_fetch[src];
        p_exec[dst] = p_exec[src];
        p_stall[dst] = p_stall[src];
    endtask

    // new fetch or a bubble
    task automatic load_fetch();
        p_valid[s_fetch] = fetch_valid;
        if (fetch_valid) begin
            p_tag[s_fetch] = model_next_tag;
            p_instr[s_fetch] = instr;
            p_fetch[s_fetch] = model_cycle;
            p_stall[s_fetch] = '0;
            model_next_tag = trace_pkg::tag_t'((int'(model_next_tag) + 1) % `TRACE_DEPTH);
        end
    endtask

    // inputs change in the NBA region so the model sees pre-edge values
    always @(posedge clk) begin
        exp_retire = 1'b0;
        if (rst) begin
            model_ready = 1'b1;
            model_cycle = '0;
            model_next_tag = '0;
            exp_retired = '0;
            exp_killed = '0;
            for (int i = 0; i < 4; i++) begin
                p_valid[i] = 1'b0;
            end
        end else begin
            // memory occupant always moves on to write-back
            if (p_valid[s_mem]) begin
                exp_retire = 1'b1;
                exp_tag = p_tag[s_mem];
                exp_instr = p_instr[s_mem];
                exp_fetch = p_fetch[s_mem];
                exp_exec = p_exec[s_mem];
                exp_stall = p_stall[s_mem];
                exp_latency = model_cycle - p_fetch[s_mem];
                exp_retired = exp_retired + 1'b1;
            end
            copy_stage(s_exec, s_mem);
            if (flush) begin
                exp_killed = exp_killed + trace_pkg::total_t'(p_valid[s_fetch])
                    + trace_pkg::total_t'(p_valid[s_decode]);
                p_valid[s_exec] = 1'b0;
                p_valid[s_decode] = 1'b0;
                load_fetch();
            end else if (stall) begin
                p_valid[s_exec] = 1'b0;
                if (p_valid[s_fetch]) begin
                    p_stall[s_fetch] = p_stall[s_fetch] + 1'b1;
                end
                if (p_valid[s_decode]) begin
                    p_stall[s_decode] = p_stall[s_decode] + 1'b1;
                end
            end else begin
                copy_stage(s_decode, s_exec);
                p_exec[s_exec] = model_cycle;
                copy_stage(s_fetch, s_decode);
                load_fetch();
            end
            model_cycle = model_cycle + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checking and monitor
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
            mismatch_errors++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        retire_rec_t rec;
        neg_count++;
        if (model_ready) begin
            check_value("retire", 32'(exp_retire), 32'(retire));
            check_value("retired_count", 32'(exp_retired), 32'(retired_count));
            check_value("killed_count", 32'(exp_killed), 32'(killed_count));
            if (retire) begin
                rec.tag = retire_tag;
                rec.instr = retire_instr;
                rec.fetch = retire_fetch_cycle;
                rec.exec = retire_exec_cycle;
                rec.latency = retire_latency;
                rec.stall = retire_stall_cycles;
                rec.at = neg_count;
                ret_q.push_back(rec);
                if (exp_retire) begin
                    check_value("retire_tag", 32'(exp_tag), 32'(retire_tag));
                    check_value("retire_instr", exp_instr, retire_instr);
                    check_value("retire_fetch_cycle", 32'(exp_fetch), 32'(retire_fetch_cycle));
                    check_value("retire_exec_cycle", 32'(exp_exec), 32'(retire_exec_cycle));
                    check_value("retire_latency", 32'(exp_latency), 32'(retire_latency));
                    check_value("retire_stall_cycles", 32'(exp_stall),
                                32'(retire_stall_cycles));
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic drive_cycle(input logic fv, input trace_pkg::instr_t word,
                               input logic st, input logic fl);
        @(posedge clk);
        fetch_valid <= fv;
        instr <= word;
        stall <= st;
        flush <= fl;
    endtask

    // two cycles of reset with idle inputs
    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        fetch_valid <= 1'b0;
        instr <= '0;
        stall <= 1'b0;
        flush <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        ret_q.delete();
    endtask

    // polled at the rising edge
    // the monitor fills the queue at the falling one
    task automatic wait_retires(input int n, input int limit);
        int waited;
        waited = 0;
        while (ret_q.size() < n && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (ret_q.size() < n) begin
            $display("timeout at %0t: waited for %0d retires but saw only %0d",
                     $time, n, ret_q.size());
            other_errors++;
        end
    endtask

    task automatic check_record(input int idx, input trace_pkg::instr_t word,
                                input int tag, input int fetch, input int stalls);
        if (ret_q.size() > idx) begin
            check_value("retire_instr", word, ret_q[idx].instr);
            check_value("retire_tag", tag, 32'(ret_q[idx].tag));
            check_value("retire_fetch_cycle", fetch, 32'(ret_q[idx].fetch));
            check_value("retire_stall_cycles", stalls, 32'(ret_q[idx].stall));
            check_value("retire_latency", 4 + stalls, 32'(ret_q[idx].latency));
            check_value("retire_exec_cycle", fetch + 2 + stalls, 32'(ret_q[idx].exec));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        apply_reset();
        @(negedge clk);
        check_value("retire", 0, 32'(retire));
        check_value("retired_count", 0, 32'(retired_count));
        check_value("killed_count", 0, 32'(killed_count));
        check_value("retire_latency", 0, 32'(retire_latency));
    endtask

    task automatic test_single();
        apply_reset();
        drive_cycle(1'b1, 32'h0badc0de, 1'b0, 1'b0);
        drive_cycle(1'b0, '0, 1'b0, 1'b0);
        wait_retires(1, 20);
        // first retire after reset carries tag 0
        check_record(0, 32'h0badc0de, 0, first_fetch, 0);
        // pulse is one cycle only
        repeat (6) @(posedge clk);
        @(negedge clk);
        check_value("retire count", 1, ret_q.size());
        check_value("retired_count", 1, 32'(retired_count));
    endtask

    task automatic test_stream();
        apply_reset();
        for (int i = 0; i < 10; i++) begin
            drive_cycle(1'b1, 32'h1000_0000 + i, 1'b0, 1'b0);
        end
        drive_cycle(1'b0, '0, 1'b0, 1'b0);
        wait_retires(10, 30);
        if (ret_q.size() >= 10) begin
            for (int i = 0; i < 10; i++) begin
                check_record(i, 32'h1000_0000 + i, i % `TRACE_DEPTH, first_fetch + i, 0);
                // consecutive cycles
                check_value("retire cycle", ret_q[0].at + i, ret_q[i].at);
            end
        end
        @(negedge clk);
        check_value("retired_count", 10, 32'(retired_count));
    endtask

    // A to execute, B in decode, C in fetch, then k stall edges
    task automatic test_stall(input int k);
        apply_reset();
        drive_cycle(1'b1, 32'haaaa_0001, 1'b0, 1'b0);
        drive_cycle(1'b1, 32'hbbbb_0002, 1'b0, 1'b0);
        drive_cycle(1'b1, 32'hcccc_0003, 1'b0, 1'b0);
        repeat (k) drive_cycle(1'b0, '0, 1'b1, 1'b0);
        drive_cycle(1'b0, '0, 1'b0, 1'b0);
        wait_retires(3, 30 + k);
        check_record(0, 32'haaaa_0001, 0, first_fetch, 0);
        check_record(1, 32'hbbbb_0002, 1, first_fetch + 1, k);
        check_record(2, 32'hcccc_0003, 2, first_fetch + 2, k);
    endtask

    // flush with A in memory, B in execute, C and D killed, E fetched
    task automatic test_flush();
        apply_reset();
        drive_cycle(1'b1, 32'h0000_00a0, 1'b0, 1'b0);
        drive_cycle(1'b1, 32'h0000_00b0, 1'b0, 1'b0);
        drive_cycle(1'b1, 32'h0000_00c0, 1'b0, 1'b0);
        drive_cycle(1'b1, 32'h0000_00d0, 1'b0, 1'b0);
        drive_cycle(1'b1, 32'h0000_00e0, 1'b0, 1'b1);
        drive_cycle(1'b0, '0, 1'b0, 1'b0);
        wait_retires(3, 30);
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_value("retire count", 3, ret_q.size());
        check_record(0, 32'h0000_00a0, 0, first_fetch, 0);
        check_record(1, 32'h0000_00b0, 1, first_fetch + 1, 0);
        check_record(2, 32'h0000_00e0, 4, first_fetch + 4, 0);
        check_value("killed_count", 2, 32'(killed_count));
        check_value("retired_count", 3, 32'(retired_count));
    endtask

    task automatic test_random();
        logic [31:0] seed;
        logic fv;
        logic st;
        logic fl;
        seed = 32'd24;
        apply_reset();
        for (int i = 0; i < 300; i++) begin
            seed = lcg_next(seed);
            fv = seed[28];
            st = (seed[27:26] == 2'b00);
            fl = (seed[25:22] == 4'b0000);
            seed = lcg_next(seed);
            drive_cycle(fv, seed, st, fl);
        end
        // pipeline is five stages deep plus the retire register
        repeat (8) drive_cycle(1'b0, '0, 1'b0, 1'b0);
        @(negedge clk);
        check_value("retired_count", 32'(exp_retired), 32'(retired_count));
        check_value("killed_count", 32'(exp_killed), 32'(killed_count));
        check_value("retire count", 32'(exp_retired), ret_q.size());
    endtask

    initial begin
        rst = 1'b1;
        fetch_valid = 1'b0;
        instr = '0;
        stall = 1'b0;
        flush = 1'b0;
        test_reset_state();
        test_single();
        test_stream();
        test_stall(3);
        test_flush();
        test_random();
        $display("errors: %0d value mismatches, %0d other failures",
                 mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+rtl
rtl/trace_pkg.sv
rtl/stage_tracker.sv
rtl/trace_table.sv
rtl/retire_reporter.sv
rtl/pipe_trace_top.sv
sim/tb_pipe_trace.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the pipeline trace testbench with verilator, run it, check the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f vlog.f \
    --top-module tb_pipe_trace \
    --Mdir obj_dir \
    -o sim_pipe_trace

out=$(./obj_dir/sim_pipe_trace)
echo "$out"

if echo "$out" | grep -q "^Verification passed$"; then
    exit 0
else
    exit 1
fi
